//--- files.f
hdl/snake_pkg.sv
hdl/snake_body_map.sv
hdl/apple_locator.sv
hdl/frame_tracker.sv
hdl/snake_frame_top.sv
tb/clock_gen.sv
tb/tb_snake_frame.sv

//--- hdl/apple_locator.sv
`timescale 1ns/100ps

module apple_locator #(
    parameter int grid_w = 16,
    parameter int grid_h = 12
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  snake_pkg::map_cmd_t           cmd,
    input  logic [snake_pkg::coord_w-1:0] cmd_x,
    input  logic [snake_pkg::coord_w-1:0] cmd_y,
    input  logic [snake_pkg::coord_w-1:0] scan_x,
    input  logic [snake_pkg::coord_w-1:0] scan_y,
    output logic                          apple,
    output logic                          border
);

    import snake_pkg::*;

    logic [coord_w-1:0] apple_x;
    logic [coord_w-1:0] apple_y;
    logic               apple_valid;

    // ----------------------------------------------------------------------
    // Apple position
    // ----------------------------------------------------------------------

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            apple_valid <= 1'b0;
        end
        else if (cmd == cmd_place_apple) begin
            apple_valid <= 1'b1;  // Stays set, a new apple just moves it.
        end
    end

    always_ff @(posedge clk) begin
        if (cmd == cmd_place_apple) begin
            apple_x <= cmd_x;
            apple_y <= cmd_y;
        end
    end

    assign apple = apple_valid && (apple_x == scan_x) && (apple_y == scan_y);

    // ----------------------------------------------------------------------
    // Border test
    // ----------------------------------------------------------------------

    // The wall is the outermost ring of tiles and never moves.
    assign border = (scan_x == '0) ||
                    (scan_y == '0) ||
                    (scan_x == coord_w'(grid_w - 1)) ||
                    (scan_y == coord_w'(grid_h - 1));

endmodule

//--- hdl/frame_tracker.sv
`timescale 1ns/100ps

module frame_tracker #(
    parameter int grid_w = 16,
    parameter int grid_h = 12
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  logic                          enable,
    input  logic                          body,
    input  logic                          head,
    input  logic                          apple,
    input  logic                          border,
    output logic [snake_pkg::coord_w-1:0] scan_x,
    output logic [snake_pkg::coord_w-1:0] scan_y,
    output snake_pkg::obj_code_t          obj_code,
    output logic                          diff
);

    import snake_pkg::*;

    // Last code reported for every tile, indexed by row, then column.
    obj_code_t frame [grid_h][grid_w];

    obj_code_t stored;
    obj_code_t cur_obj;
    logic      last_x;
    logic      last_y;

    assign last_x = (scan_x == coord_w'(grid_w - 1));
    assign last_y = (scan_y == coord_w'(grid_h - 1));

    // ----------------------------------------------------------------------
    // Raster scan
    // ----------------------------------------------------------------------

    // x runs first; the scan wraps to the top left after the last tile.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            scan_x <= '0;
            scan_y <= '0;
        end
        else if (enable) begin
            if (last_x) begin
                scan_x <= '0;
                scan_y <= last_y ? '0 : scan_y + 1'b1;
            end
            else begin
                scan_x <= scan_x + 1'b1;
            end
        end
    end

    // ----------------------------------------------------------------------
    // Object priority and diff
    // ----------------------------------------------------------------------

    always_comb begin
        if (border) begin
            cur_obj = border_c;
        end
        else if (body) begin
            cur_obj = snake_body;  // Body wins over a head on the same tile.
        end
        else if (head) begin
            cur_obj = snake_head;
        end
        else if (apple) begin
            cur_obj = apple_c;
        end
        else begin
            cur_obj = blank;
        end
    end

    assign stored   = frame[scan_y][scan_x];
    assign obj_code = cur_obj;
    assign diff     = (cur_obj != stored);

    // ----------------------------------------------------------------------
    // Stored frame
    // ----------------------------------------------------------------------

    // An enabled edge commits the current object, so the painter and the
    // stored frame agree on this tile from then on.
    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            for (int r = 0; r < grid_h; r++) begin
                for (int c = 0; c < grid_w; c++) begin
                    frame[r][c] <= blank;
                end
            end
        end
        else if (enable) begin
            frame[scan_y][scan_x] <= cur_obj;
        end
    end

    // The wall comes from the apple locator and must sit on the edge of the
    // grid that this scan walks, or edge tiles would show map objects.
    a_border_on_edge : assert property (
        @(posedge clk) disable iff (!nrst)
        border == ((scan_x == '0) || (scan_y == '0) || last_x || last_y)
    ) else $error("border input disagrees with the edge of the scanned grid");

endmodule

//--- hdl/snake_body_map.sv
`timescale 1ns/100ps

module snake_body_map #(
    parameter int grid_w = 16,
    parameter int grid_h = 12
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  snake_pkg::map_cmd_t           cmd,
    input  logic [snake_pkg::coord_w-1:0] cmd_x,
    input  logic [snake_pkg::coord_w-1:0] cmd_y,
    input  logic [snake_pkg::coord_w-1:0] scan_x,
    input  logic [snake_pkg::coord_w-1:0] scan_y,
    output logic                          body,
    output logic                          head
);

    import snake_pkg::*;

    logic [grid_h-1:0][grid_w-1:0] segs;  // One bit per tile, row major.
    logic [coord_w-1:0]            head_x;
    logic [coord_w-1:0]            head_y;
    logic                          head_valid;
    logic                          cmd_in_grid;
    logic                          scan_in_grid;

    assign cmd_in_grid  = (int'(cmd_x) < grid_w) && (int'(cmd_y) < grid_h);
    assign scan_in_grid = (int'(scan_x) < grid_w) && (int'(scan_y) < grid_h);

    // ----------------------------------------------------------------------
    // Segment bitmap and head flag
    // ----------------------------------------------------------------------

    always_ff @(posedge clk, negedge nrst) begin
        if (!nrst) begin
            segs       <= '0;
            head_valid <= 1'b0;  // No snake on the board until placed.
        end
        else if (cmd_in_grid) begin
            case (cmd)
                cmd_set_body:   segs[cmd_y][cmd_x] <= 1'b1;
                cmd_clear_body: segs[cmd_y][cmd_x] <= 1'b0;
                cmd_move_head:  head_valid <= 1'b1;
                default: ;
            endcase
        end
    end

    // The head position only matters once head_valid is set.
    always_ff @(posedge clk) begin
        if (cmd == cmd_move_head && cmd_in_grid) begin
            head_x <= cmd_x;
            head_y <= cmd_y;
        end
    end

    // ----------------------------------------------------------------------
    // Lookup at the scan tile
    // ----------------------------------------------------------------------

    // Both answers are combinational, so the tracker sees the map as it
    // stood after the last clock edge.
    assign body = scan_in_grid && segs[scan_y][scan_x];
    assign head = head_valid && (head_x == scan_x) && (head_y == scan_y);

    // The controller must keep every map command on the grid. A stray
    // coordinate would otherwise be dropped without notice.
    a_cmd_in_grid : assert property (
        @(posedge clk) disable iff (!nrst)
        (cmd != cmd_none) |-> cmd_in_grid
    ) else $error("map command outside the %0d by %0d grid", grid_w, grid_h);

endmodule

//--- hdl/snake_frame_top.sv
`timescale 1ns/100ps

module snake_frame_top #(
    parameter int grid_w = 16,
    parameter int grid_h = 12
) (
    input  logic                          clk,
    input  logic                          nrst,
    input  snake_pkg::map_cmd_t           cmd,
    input  logic [snake_pkg::coord_w-1:0] cmd_x,
    input  logic [snake_pkg::coord_w-1:0] cmd_y,
    input  logic                          enable,
    output snake_pkg::obj_code_t          obj_code,
    output logic [snake_pkg::coord_w-1:0] x,
    output logic [snake_pkg::coord_w-1:0] y,
    output logic                          diff
);

    // Lookup answers for the tile under the scan.
    logic body;
    logic head;
    logic apple;
    logic border;

    // ----------------------------------------------------------------------
    // Map parts
    // ----------------------------------------------------------------------

    // Both parts see every command and pick out their own opcodes. The scan
    // position leaves the tracker as x and y and doubles as the lookup tile.
    snake_body_map #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) u_body_map (
        .clk    (clk),
        .nrst   (nrst),
        .cmd    (cmd),
        .cmd_x  (cmd_x),
        .cmd_y  (cmd_y),
        .scan_x (x),
        .scan_y (y),
        .body   (body),
        .head   (head)
    );

    apple_locator #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) u_apple_locator (
        .clk    (clk),
        .nrst   (nrst),
        .cmd    (cmd),
        .cmd_x  (cmd_x),
        .cmd_y  (cmd_y),
        .scan_x (x),
        .scan_y (y),
        .apple  (apple),
        .border (border)
    );

    // ----------------------------------------------------------------------
    // Scanner and change reporting
    // ----------------------------------------------------------------------

    frame_tracker #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) u_frame_tracker (
        .clk      (clk),
        .nrst     (nrst),
        .enable   (enable),
        .body     (body),
        .head     (head),
        .apple    (apple),
        .border   (border),
        .scan_x   (x),
        .scan_y   (y),
        .obj_code (obj_code),
        .diff     (diff)
    );

endmodule

//--- hdl/snake_pkg.sv
package snake_pkg;

    // ----------------------------------------------------------------------
    // Grid coordinates
    // ----------------------------------------------------------------------

    // One word width serves both x and y, so grids up to 16 by 16 fit.
    localparam int coord_w = 4;

    // ----------------------------------------------------------------------
    // Tile contents as reported to the display painter
    // ----------------------------------------------------------------------

    typedef enum logic [2:0] {
        blank      = 3'd0,
        snake_head = 3'd1,
        snake_body = 3'd2,
        apple_c    = 3'd3,
        border_c   = 3'd4
    } obj_code_t;

    // ----------------------------------------------------------------------
    // Map commands from the game controller
    // ----------------------------------------------------------------------

    // Each command carries one tile coordinate and takes effect at the next
    // rising clock edge.
    typedef enum logic [2:0] {
        cmd_none        = 3'd0,
        cmd_set_body    = 3'd1,  // Mark a body segment.
        cmd_clear_body  = 3'd2,  // Remove a body segment.
        cmd_move_head   = 3'd3,  // Put the head on a tile.
        cmd_place_apple = 3'd4   // Put the apple on a tile.
    } map_cmd_t;

endpackage

//--- tb/clock_gen.sv
`timescale 1ns/100ps

module clock_gen (
    output logic clk,
    output logic nrst
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period.
    end

    // Reset is held low for the first four rising edges.
    initial begin
        nrst = 1'b0;
        repeat (4) @(posedge clk);
        nrst <= 1'b1;
    end

endmodule

//--- tb/snake_frame_trace.txt
# cmd cmd_x cmd_y enable count diff code x y  (x y give the scan tile at the first step)
# cmd: 0 none 1 set_body 2 clear_body 3 move_head 4 place_apple; code 7 is not checked
# first frame after reset, border tiles report border_c
0 0 0 1 17 1 4 0 0
0 0 0 1 14 0 0 1 1
0 0 0 1 2 1 4 15 1
0 0 0 1 14 0 0 1 2
0 0 0 1 2 1 4 15 2
0 0 0 1 14 0 0 1 3
0 0 0 1 2 1 4 15 3
0 0 0 1 14 0 0 1 4
0 0 0 1 2 1 4 15 4
0 0 0 1 14 0 0 1 5
0 0 0 1 2 1 4 15 5
0 0 0 1 14 0 0 1 6
0 0 0 1 2 1 4 15 6
0 0 0 1 14 0 0 1 7
0 0 0 1 2 1 4 15 7
0 0 0 1 14 0 0 1 8
0 0 0 1 2 1 4 15 8
0 0 0 1 14 0 0 1 9
0 0 0 1 2 1 4 15 9
0 0 0 1 14 0 0 1 10
0 0 0 1 17 1 4 15 10
# apple at 5,3, head at 8,6, body at 7,6 and 6,6
4 5 3 0 1 0 7 0 0
3 8 6 0 1 0 7 0 0
1 7 6 0 1 0 7 0 0
1 6 6 0 1 0 7 0 0
# second frame shows the new objects
0 0 0 1 53 0 7 0 0
0 0 0 1 1 1 3 5 3
0 0 0 1 48 0 7 6 3
0 0 0 1 2 1 2 6 6
0 0 0 1 1 1 1 8 6
0 0 0 1 87 0 7 9 6
# apple moves to 10,8, body grows onto the head tile, body leaves 6,6
4 10 8 0 1 0 7 0 0
1 8 6 0 1 0 7 0 0
2 6 6 0 1 0 7 0 0
# third frame reports the old apple and the cleared tile as blank
0 0 0 1 53 0 7 0 0
0 0 0 1 1 1 0 5 3
0 0 0 1 48 0 7 6 3
0 0 0 1 1 1 0 6 6
0 0 0 1 1 0 2 7 6
0 0 0 1 1 1 2 8 6
0 0 0 1 33 0 7 9 6
0 0 0 1 1 1 3 10 8
0 0 0 1 53 0 7 11 8
# fourth frame with an unchanged map, paused halfway with enable low
0 0 0 1 100 0 7 0 0
0 0 0 0 5 0 7 4 6
0 0 0 1 92 0 7 4 6

//--- tb/tb_snake_frame.sv
`timescale 1ns/100ps

module tb_snake_frame;

    import snake_pkg::*;

    localparam int grid_w  = 16;
    localparam int grid_h  = 12;
    localparam int no_code = 7;  // Trace value that leaves obj_code unchecked.

    logic               clk;
    logic               nrst;
    map_cmd_t           cmd;
    logic [coord_w-1:0] cmd_x;
    logic [coord_w-1:0] cmd_y;
    logic               enable;
    obj_code_t          obj_code;
    logic [coord_w-1:0] x;
    logic [coord_w-1:0] y;
    logic               diff;

    // One entry per trace line, one queue per column.
    int t_cmd [$];
    int t_cmd_x [$];
    int t_cmd_y [$];
    int t_enable [$];
    int t_count [$];
    int t_diff [$];
    int t_code [$];
    int t_x [$];
    int t_y [$];

    int exp_x;
    int exp_y;
    int cur_line;
    int cycle_count;
    int cycle_limit;
    int total_steps;
    string problem;

    clock_gen u_clock_gen (
        .clk  (clk),
        .nrst (nrst)
    );

    snake_frame_top #(
        .grid_w (grid_w),
        .grid_h (grid_h)
    ) uut (
        .clk      (clk),
        .nrst     (nrst),
        .cmd      (cmd),
        .cmd_x    (cmd_x),
        .cmd_y    (cmd_y),
        .enable   (enable),
        .obj_code (obj_code),
        .x        (x),
        .y        (y),
        .diff     (diff)
    );

    // ----------------------------------------------------------------------
    // Helpers
    // ----------------------------------------------------------------------

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d (trace step %0d)",
                     $time, what, actual, expected, cur_line);
            $display("TB FAILED");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    // The scan moves along x first and wraps to the top left after the last tile.
    task automatic next_raster_tile();
        if (exp_x == grid_w - 1) begin
            exp_x = 0;
            exp_y = (exp_y == grid_h - 1) ? 0 : exp_y + 1;
        end
        else begin
            exp_x = exp_x + 1;
        end
    endtask

    task automatic load_trace(output string why, output int steps);
        int    fd;
        int    n;
        int    f [9];
        string line;
        why   = "";
        steps = 0;
        fd    = $fopen("tb/snake_frame_trace.txt", "r");
        if (fd == 0) begin
            why = "the trace file tb/snake_frame_trace.txt could not be opened";
        end
        else begin
            while (!$feof(fd) && why == "") begin
                line = "";
                n = $fgets(line, fd);
                n = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n == 9) begin
                    t_cmd.push_back(f[0]);
                    t_cmd_x.push_back(f[1]);
                    t_cmd_y.push_back(f[2]);
                    t_enable.push_back(f[3]);
                    t_count.push_back(f[4]);
                    t_diff.push_back(f[5]);
                    t_code.push_back(f[6]);
                    t_x.push_back(f[7]);
                    t_y.push_back(f[8]);
                    steps += f[4];
                end
                else if (n > 0) begin
                    why = $sformatf("trace line after step %0d is malformed", t_cmd.size());
                end
            end
            $fclose(fd);
            if (why == "" && t_cmd.size() == 0) begin
                why = "the trace file holds no steps";
            end
        end
    endtask

    // Drive one cycle on the rising edge and check the outputs half a cycle later.
    task automatic run_step(input map_cmd_t c, input int cx, input int cy,
                            input logic en, input int e_diff, input int e_code);
        @(posedge clk);
        cmd    <= c;
        cmd_x  <= coord_w'(cx);
        cmd_y  <= coord_w'(cy);
        enable <= en;
        @(negedge clk);
        check_value(x, exp_x, "x");
        check_value(y, exp_y, "y");
        if (en) begin
            check_value(diff, e_diff, "diff");
            if (e_code != no_code) begin
                check_value(obj_code, e_code, "obj_code");
            end
            next_raster_tile();
        end
    endtask

    // ----------------------------------------------------------------------
    // Timeout
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: the run went past %0d clock cycles.", cycle_limit);
            $display("TB FAILED");
            $fatal(1, "simulation timed out");
        end
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------

    initial begin
        cmd        = cmd_none;
        cmd_x      = '0;
        cmd_y      = '0;
        enable     = 1'b0;
        exp_x      = 0;
        exp_y      = 0;
        void'($urandom(68678));
        load_trace(problem, total_steps);
        if (problem != "") begin
            $display("Cannot run: %s.", problem);
            $display("TB FAILED");
            $fatal(1, "trace not usable");
        end
        else begin
            cycle_limit = 4 * total_steps + 100;
            wait (nrst === 1'b1);
            for (int i = 0; i < t_cmd.size(); i++) begin
                cur_line = i + 1;
                exp_x    = t_x[i];
                exp_y    = t_y[i];
                for (int k = 0; k < t_count[i]; k++) begin
                    run_step((k == 0) ? map_cmd_t'(t_cmd[i]) : cmd_none,
                             t_cmd_x[i], t_cmd_y[i], t_enable[i] != 0,
                             t_diff[i], t_code[i]);
                end
                // A frozen scan must hold its tile through the idle gap.
                repeat ($urandom_range(3, 0)) begin
                    run_step(cmd_none, 0, 0, 1'b0, 0, no_code);
                end
            end
            $display("TB PASSED");
            $finish;
        end
    end

endmodule
